/* hdl/dnn_out_pkg.sv */
// Output layer constants and the fixed-point word union
`default_nettype none

package dnn_out_pkg;

	// Fixed-point format, sign + integer + fraction
	localparam int WIDTH     = 16;              // Bits per word
	localparam int INT_BITS  = 5;               // Integer part
	localparam int FRAC_BITS = 10;              // Fraction part

	// Output layer geometry
	localparam int P     = 8;                   // Neurons in output layer
	localparam int Z     = 2;                   // Neurons per clock
	localparam int DEPTH = P / Z;               // Entries per del collection
	localparam int CPC   = DEPTH + 2;           // Clocks per junction period

	// Whole network, needed only for the answer delay
	localparam int L         = 3;               // Layers in network
	localparam int ANS_DELAY = CPC * (L - 1);   // Input-to-output latency in clocks

	// Collection address, at least one bit even for a single entry
	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// One fixed-point word, seen either as a number or as its fields
	typedef union packed {
		logic signed [WIDTH-1:0] num;           // Two's-complement value
		struct packed {
			logic                 sign;         // MSB
			logic [INT_BITS-1:0]  int_part;     // Integer bits
			logic [FRAC_BITS-1:0] frac_part;    // Fraction bits
		} fld;
	} fix_word_u;

endpackage

`default_nettype wire

/* hdl/del_cost_unit.sv */
// Answer delay line and cross-entropy del computation for the output layer
`default_nettype none
`timescale 1ns/10ps

module del_cost_unit (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  logic                                         act_valid_i, // One strobe per Z activations
	input  dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  act_i,       // Final activations
	input  logic [dnn_out_pkg::Z-1:0]                    ans_i,       // Ideal answers at network input time
	output logic [dnn_out_pkg::Z-1:0]                    ans_o,       // Same answers at output time
	output logic                                         del_we_o,    // Write strobe toward del memory
	output dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  del_wdata_o  // Z del words
);

	// Answers travel alongside the activations through all earlier layers
	logic [dnn_out_pkg::Z-1:0] ans_sr [dnn_out_pkg::ANS_DELAY];

	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] ideal; // 1.0 or 0.0 per answer bit
	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] diff;  // Activation minus ideal

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int k = 0; k < dnn_out_pkg::ANS_DELAY; k++) begin
				ans_sr[k] <= '0;
			end
		end else begin
			ans_sr[0] <= ans_i; // Shift in every clock, not only on strobes
			for (int k = 1; k < dnn_out_pkg::ANS_DELAY; k++) begin
				ans_sr[k] <= ans_sr[k-1];
			end
		end
	end

	assign ans_o = ans_sr[dnn_out_pkg::ANS_DELAY-1]; // Last stage of the line

	// Cross-entropy with softmax/sigmoid output: del is simply a - y
	always_comb begin
		for (int i = 0; i < dnn_out_pkg::Z; i++) begin
			ideal[i] = '0;
			// Answer bit 1 means integer part one, all fraction bits zero
			ideal[i].fld.int_part = dnn_out_pkg::INT_BITS'(ans_o[i]);
			diff[i].num = act_i[i].num - ideal[i].num; // Wraps on overflow
		end
	end

	// Write strobe follows the activation strobe by one clock
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			del_we_o <= 1'b0;
		end else begin
			del_we_o <= act_valid_i;
		end
	end

	// Payload only loads on a strobe
	always_ff @(posedge clk) begin
		if (act_valid_i) begin
			del_wdata_o <= diff;
		end
	end

endmodule

`default_nettype wire

/* hdl/del_pingpong_mem.sv */
// Two-collection ping-pong del memory with write addressing and bank swap
`default_nettype none
`timescale 1ns/10ps

module del_pingpong_mem (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  logic                                         del_we_i,     // Write one entry
	input  dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  del_wdata_i,  // Z del words
	input  logic                                         rd_en_i,      // Read one entry
	input  logic [dnn_out_pkg::ADDR_W-1:0]               rd_addr_i,    // Entry in read bank
	output logic                                         frame_ready_o, // Pulse, read bank holds a frame
	output dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  rd_data_o     // Registered read data
);

	localparam logic [dnn_out_pkg::ADDR_W-1:0] LAST_ADDR =
		dnn_out_pkg::ADDR_W'(dnn_out_pkg::DEPTH - 1);

	// Two collections, DEPTH entries each, Z words per entry
	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] mem [2][dnn_out_pkg::DEPTH];

	logic                              wr_bank; // Collection being filled
	logic                              rd_bank; // Collection being drained
	logic [dnn_out_pkg::ADDR_W-1:0]    wr_addr; // Next entry in write bank
	logic                              wr_last; // This write completes the frame

	assign rd_bank = ~wr_bank;                  // Reads never touch the bank being written
	assign wr_last = del_we_i && (wr_addr == LAST_ADDR);

	// Write address counter and bank pointer
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_addr       <= '0;
			wr_bank       <= 1'b0;
			frame_ready_o <= 1'b0;
		end else begin
			frame_ready_o <= wr_last; // One-cycle pulse after the swap
			if (wr_last) begin
				wr_addr <= '0;
				wr_bank <= ~wr_bank; // Finished frame becomes the read bank
			end else if (del_we_i) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	// Storage array, no reset
	always_ff @(posedge clk) begin
		if (del_we_i) begin
			mem[wr_bank][wr_addr] <= del_wdata_i;
		end
	end

	// One clock read latency
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_data_o <= mem[rd_bank][rd_addr_i];
		end
	end

endmodule

`default_nettype wire

/* hdl/del_readout.sv */
// Sequential read-out of a finished del collection toward the previous layer
`default_nettype none
`timescale 1ns/10ps

module del_readout (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  logic                                         frame_ready_i, // Start of a frame
	input  dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  rd_data_i,     // From del memory
	output logic                                         rd_en_o,       // Read request
	output logic [dnn_out_pkg::ADDR_W-1:0]               rd_addr_o,     // Entry to read
	output logic                                         del_valid_o,   // del_o holds a valid entry
	output dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  del_o          // Z del words to previous layer
);

	localparam logic [dnn_out_pkg::ADDR_W-1:0] LAST_ADDR =
		dnn_out_pkg::ADDR_W'(dnn_out_pkg::DEPTH - 1);

	// Address walk 0..DEPTH-1, one entry per clock
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_en_o   <= 1'b0;
			rd_addr_o <= '0;
		end else if (frame_ready_i) begin
			rd_en_o   <= 1'b1; // New frame restarts the walk
			rd_addr_o <= '0;
		end else if (rd_en_o) begin
			if (rd_addr_o == LAST_ADDR) begin
				rd_en_o <= 1'b0; // Frame done
			end else begin
				rd_addr_o <= rd_addr_o + 1'b1;
			end
		end
	end

	// Valid trails the read enable by the memory latency
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			del_valid_o <= 1'b0;
		end else begin
			del_valid_o <= rd_en_o;
		end
	end

	assign del_o = rd_data_i; // Memory output is already registered

endmodule

`default_nettype wire

/* hdl/output_layer_block.sv */
// Output layer top level: cost unit, ping-pong del memory and read-out
`default_nettype none
`timescale 1ns/10ps

module output_layer_block (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  logic                                         act_valid_i, // Activation strobe
	input  dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  act_i,       // From last hidden layer
	input  logic [dnn_out_pkg::Z-1:0]                    ans_i,       // Ideal outputs at input time
	output logic [dnn_out_pkg::Z-1:0]                    ans_o,       // Ideal outputs at output time
	output logic                                         del_valid_o, // del_o valid
	output dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0]  del_o        // To previous layer BP
);

	// Producer to buffer
	logic                                        del_we;
	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] del_wdata;

	// Buffer to consumer and back
	logic                                        frame_ready;
	logic                                        rd_en;
	logic [dnn_out_pkg::ADDR_W-1:0]              rd_addr;
	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] rd_data;

	del_cost_unit del_cost_unit_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.act_valid_i (act_valid_i),
		.act_i       (act_i),
		.ans_i       (ans_i),
		.ans_o       (ans_o),
		.del_we_o    (del_we),
		.del_wdata_o (del_wdata)
	);

	del_pingpong_mem del_pingpong_mem_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.del_we_i      (del_we),
		.del_wdata_i   (del_wdata),
		.rd_en_i       (rd_en),
		.rd_addr_i     (rd_addr),
		.frame_ready_o (frame_ready),
		.rd_data_o     (rd_data)
	);

	del_readout del_readout_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.frame_ready_i (frame_ready),
		.rd_data_i     (rd_data),
		.rd_en_o       (rd_en),
		.rd_addr_o     (rd_addr),
		.del_valid_o   (del_valid_o),
		.del_o         (del_o)
	);

endmodule

`default_nettype wire

/* sim/tb_output_layer.sv */
// Random-stimulus testbench for the output layer block with a cycle model and compare tasks
`default_nettype none
`timescale 1ns/10ps

module tb_output_layer;

	logic                                        clk = 1'b0;
	logic                                        rst_n_i;
	logic                                        act_valid_i;
	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] act_i;
	logic [dnn_out_pkg::Z-1:0]                   ans_i;
	logic [dnn_out_pkg::Z-1:0]                   ans_o;
	logic                                        del_valid_o;
	dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] del_o;

	int frames_total = 40; // First half back to back, second half spread out
	int wait_limit   = 50; // Cycles a frame may take to show up
	int cyc          = 0;  // Rising edges so far

	int ans_errors    = 0;
	int del_errors    = 0;
	int timing_errors = 0;
	int timeouts      = 0;

	logic [dnn_out_pkg::Z-1:0] ans_hist [$];  // Answers still inside the delay line
	dnn_out_pkg::fix_word_u    exp_del [$];   // Expected del words in strobe order
	int                        exp_start [$]; // Cycle where each frame should rise

	output_layer_block output_layer_block_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.act_valid_i (act_valid_i),
		.act_i       (act_i),
		.ans_i       (ans_i),
		.ans_o       (ans_o),
		.del_valid_o (del_valid_o),
		.del_o       (del_o)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic check_ans(input logic [dnn_out_pkg::Z-1:0] got,
		input logic [dnn_out_pkg::Z-1:0] exp);
		if (got !== exp) begin
			ans_errors++;
			$display("mismatch ans_o: got %h expected %h at cycle %0d", got, exp, cyc);
		end
	endtask

	task automatic check_del(input int lane, input dnn_out_pkg::fix_word_u got,
		input dnn_out_pkg::fix_word_u exp);
		if (got !== exp) begin
			del_errors++;
			$display("mismatch del_o[%0d]: got %h expected %h at cycle %0d",
				lane, got.num, exp.num, cyc);
		end
	endtask

	// One clock of stimulus, entered and left 1 ns after a rising edge
	task automatic drive_cycle(input logic valid, input logic last);
		dnn_out_pkg::fix_word_u [dnn_out_pkg::Z-1:0] nxt_act;
		dnn_out_pkg::fix_word_u                      ideal;
		dnn_out_pkg::fix_word_u                      exp_w;
		logic [dnn_out_pkg::Z-1:0]                   nxt_ans;
		check_ans(ans_o, ans_hist[0]);  // Oldest queued answer is on ans_o now
		nxt_ans = dnn_out_pkg::Z'($urandom());
		for (int i = 0; i < dnn_out_pkg::Z; i++) begin
			nxt_act[i].num = dnn_out_pkg::WIDTH'($urandom());
			if ($urandom_range(0, 7) == 0) begin
				// Close to the most negative value, so minus 1.0 wraps
				nxt_act[i].fld.sign     = 1'b1;
				nxt_act[i].fld.int_part = '0;
			end
			if (valid) begin
				ideal.num = '0;
				if (ans_hist[0][i]) begin
					ideal.num = dnn_out_pkg::WIDTH'(1) << dnn_out_pkg::FRAC_BITS; // 1.0
				end
				exp_w.num = nxt_act[i].num - ideal.num; // Two's-complement wrap
				exp_del.push_back(exp_w);
			end
		end
		if (last) begin
			exp_start.push_back(cyc + 4); // Valid rises 4 edges after the last strobe
		end
		act_valid_i = valid;
		act_i       = nxt_act;  // Random words on idle cycles too
		ans_i       = nxt_ans;
		ans_hist.delete(0);
		ans_hist.push_back(nxt_ans);
		@(posedge clk);
		#1;
	endtask

	task automatic run_frames();
		logic spread;
		for (int f = 0; f < frames_total; f++) begin
			spread = (f >= frames_total / 2);
			for (int s = 0; s < dnn_out_pkg::DEPTH; s++) begin
				if (spread && s > 0) begin
					repeat ($urandom_range(0, 2)) drive_cycle(1'b0, 1'b0);
				end
				drive_cycle(1'b1, s == dnn_out_pkg::DEPTH - 1);
			end
			// Minimum gap keeps one frame in read-out while the next is written
			repeat (dnn_out_pkg::CPC - dnn_out_pkg::DEPTH) drive_cycle(1'b0, 1'b0);
			if (spread) begin
				repeat ($urandom_range(0, 3)) drive_cycle(1'b0, 1'b0);
			end
		end
		repeat (dnn_out_pkg::ANS_DELAY + 20) drive_cycle(1'b0, 1'b0); // Drain
	endtask

	task automatic check_frames();
		int waited;
		int exp_t;
		for (int f = 0; f < frames_total; f++) begin
			waited = 0;
			@(posedge clk);
			#2;
			while (!del_valid_o && waited < wait_limit) begin
				@(posedge clk);
				#2;
				waited++;
			end
			if (!del_valid_o) begin
				timeouts++;
				$display("timeout: frame %0d never raised del_valid_o", f);
				return;
			end
			if (exp_start.size() == 0) begin
				timing_errors++;
				$display("del_valid_o rose at cycle %0d with no frame sent", cyc);
				return;
			end
			exp_t = exp_start.pop_front();
			if (cyc != exp_t) begin
				timing_errors++;
				$display("frame %0d started at cycle %0d instead of %0d", f, cyc, exp_t);
			end
			for (int e = 0; e < dnn_out_pkg::DEPTH; e++) begin
				if (e > 0) begin
					@(posedge clk);
					#2;
				end
				if (!del_valid_o) begin
					timing_errors++;
					$display("del_valid_o fell inside frame %0d at entry %0d", f, e);
				end
				for (int i = 0; i < dnn_out_pkg::Z; i++) begin
					check_del(i, del_o[i], exp_del.pop_front());
				end
			end
			@(posedge clk);
			#2;
			if (del_valid_o) begin
				timing_errors++;
				$display("del_valid_o stayed high past the end of frame %0d", f);
			end
		end
		repeat (12) begin
			@(posedge clk);
			#2;
			if (del_valid_o) begin
				timing_errors++;
				$display("del_valid_o rose after the last frame at cycle %0d", cyc);
			end
		end
	endtask

	task automatic report_and_finish();
		$display("ans errors %0d, del errors %0d, timing errors %0d, timeouts %0d",
			ans_errors, del_errors, timing_errors, timeouts);
		if (ans_errors + del_errors + timing_errors + timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	initial begin
		rst_n_i     = 1'b0;
		act_valid_i = 1'b0;
		act_i       = '0;
		ans_i       = '0;
		void'($urandom(1479));  // Seed once
		for (int k = 0; k < dnn_out_pkg::ANS_DELAY; k++) begin
			ans_hist.push_back('0); // Reset clears the whole line
		end
		repeat (3) begin
			@(posedge clk);
			#1;
			check_ans(ans_o, '0);
			if (del_valid_o) begin
				timing_errors++;
				$display("del_valid_o high during reset");
			end
		end
		rst_n_i = 1'b1;
		fork
			run_frames();
			check_frames();
		join
		report_and_finish();
	end

endmodule

`default_nettype wire

/* compile.f */
hdl/dnn_out_pkg.sv
hdl/del_cost_unit.sv
hdl/del_pingpong_mem.sv
hdl/del_readout.sv
hdl/output_layer_block.sv
sim/tb_output_layer.sv

/* Makefile */
# Verilator build and run of the output layer testbench

VERILATOR ?= verilator
TOP       ?= tb_output_layer
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j $(JOBS)
PASS_MSG  ?= All tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line, not from the simulator
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
